/* hdl/aip_params.svh */
`ifndef AIP_PARAMS_SVH
`define AIP_PARAMS_SVH

// Datapath widths
`define AIP_DATA_WIDTH     32
`define AIP_CODE_WIDTH     5
`define AIP_MEM_ADDR_WIDTH 5  // 32 words per memory
`define AIP_STATUS_WIDTH   8

`define AIP_IP_ID 32'h0000_0001

// Host configuration codes
`define AIP_CODE_MEMIN0_DATA 5'd0
`define AIP_CODE_MEMIN0_ADDR 5'd1
`define AIP_CODE_MEMIN1_DATA 5'd2
`define AIP_CODE_MEMIN1_ADDR 5'd3
`define AIP_CODE_MEMOUT_DATA 5'd4
`define AIP_CODE_MEMOUT_ADDR 5'd5
`define AIP_CODE_CONF_DATA   5'd6

// Code 7 left free
`define AIP_CODE_STATUS      5'd30
`define AIP_CODE_ID          5'd31

`endif

/* hdl/aipPkg.sv */
`default_nettype none

`include "aip_params.svh"

package aipPkg;

  typedef logic [`AIP_DATA_WIDTH-1:0]     data_t;
  typedef logic [`AIP_CODE_WIDTH-1:0]     code_t;
  typedef logic [`AIP_MEM_ADDR_WIDTH-1:0] memAddr_t;
  typedef logic [`AIP_STATUS_WIDTH-1:0]   statusBits_t;

  // Status word seen by a host read
  typedef struct packed {
    logic [`AIP_DATA_WIDTH-3*`AIP_STATUS_WIDTH-1:0] zero;
    statusBits_t mask;
    statusBits_t flags;   // Pending interrupts
    statusBits_t status;  // Live core status
  } statusRead_t;

  // Same word as written by the host
  typedef struct packed {
    logic [`AIP_DATA_WIDTH-3*`AIP_STATUS_WIDTH-1:0] unusedHi;
    statusBits_t newMask;
    statusBits_t clear;
    statusBits_t unusedLo;
  } statusWrite_t;

  typedef union packed {
    statusRead_t  rd;
    statusWrite_t wr;
  } statusWord_u;

  typedef enum logic [1:0] {
    SEL_MEMOUT = 2'd0,
    SEL_STATUS = 2'd1,
    SEL_ID     = 2'd2
  } readSel_t;

endpackage

`default_nettype wire

/* hdl/aipHostDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aip_params.svh"

module aipHostDecode import aipPkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic en_i,
  input  code_t     configAIP_i,
  input  wire logic writeAIP_i,
  input  wire logic readAIP_i,
  input  data_t     dataInAIP_i,
  output logic      wrEnMemIn0_o,
  output logic      wrEnMemIn1_o,
  output memAddr_t  wrAddrMemIn0_o,
  output memAddr_t  wrAddrMemIn1_o,
  output memAddr_t  rdAddrMemOut_o,
  output logic      wrEnConf_o,
  output logic      wrEnStatus_o,
  output readSel_t  readSel_o
);

  logic     ldPtrIn0;
  logic     ldPtrIn1;
  logic     ldPtrOut;
  logic     rdMemOut;
  memAddr_t newPtr;
  memAddr_t ptrIn0;
  memAddr_t ptrIn1;
  memAddr_t ptrOut;

  // Load takes priority over increment, wraps naturally
  function automatic memAddr_t nextPtr(input memAddr_t ptr, input logic load,
                                       input logic inc, input memAddr_t loadVal);
    memAddr_t res;
    res = ptr;
    if (load)
      res = loadVal;
    else if (inc)
      res = ptr + 1'b1;
    return res;
  endfunction

  assign newPtr = dataInAIP_i[`AIP_MEM_ADDR_WIDTH-1:0];

  assign wrEnMemIn0_o = writeAIP_i && (configAIP_i == `AIP_CODE_MEMIN0_DATA);
  assign wrEnMemIn1_o = writeAIP_i && (configAIP_i == `AIP_CODE_MEMIN1_DATA);
  assign wrEnConf_o   = writeAIP_i && (configAIP_i == `AIP_CODE_CONF_DATA);
  assign wrEnStatus_o = writeAIP_i && (configAIP_i == `AIP_CODE_STATUS);

  assign ldPtrIn0 = writeAIP_i && (configAIP_i == `AIP_CODE_MEMIN0_ADDR);
  assign ldPtrIn1 = writeAIP_i && (configAIP_i == `AIP_CODE_MEMIN1_ADDR);
  assign ldPtrOut = writeAIP_i && (configAIP_i == `AIP_CODE_MEMOUT_ADDR);
  assign rdMemOut = readAIP_i && (configAIP_i == `AIP_CODE_MEMOUT_DATA);  // Read pop

  // Unmapped codes fall through to the ID
  assign readSel_o = (configAIP_i == `AIP_CODE_MEMOUT_DATA) ? SEL_MEMOUT :
                     (configAIP_i == `AIP_CODE_STATUS)      ? SEL_STATUS : SEL_ID;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ptrIn0 <= '0;
      ptrIn1 <= '0;
      ptrOut <= '0;
    end else if (en_i) begin
      ptrIn0 <= nextPtr(ptrIn0, ldPtrIn0, wrEnMemIn0_o, newPtr);
      ptrIn1 <= nextPtr(ptrIn1, ldPtrIn1, wrEnMemIn1_o, newPtr);
      ptrOut <= nextPtr(ptrOut, ldPtrOut, rdMemOut, newPtr);
    end
  end

  assign wrAddrMemIn0_o = ptrIn0;
  assign wrAddrMemIn1_o = ptrIn1;
  assign rdAddrMemOut_o = ptrOut;

  // Host strobes need a defined target
  knownCode: assert property (@(posedge clk) disable iff (!rst)
    (writeAIP_i || readAIP_i) |-> !$isunknown(configAIP_i));

endmodule

`default_nettype wire

/* hdl/aipBuffers.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aip_params.svh"

module aipBuffers import aipPkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  data_t     dataInAIP_i,
  input  wire logic wrEnMemIn0_i,
  input  wire logic wrEnMemIn1_i,
  input  memAddr_t  wrAddrMemIn0_i,
  input  memAddr_t  wrAddrMemIn1_i,
  input  memAddr_t  rdAddrMemIn0_i,
  input  memAddr_t  rdAddrMemIn1_i,
  input  wire logic wrEnConf_i,
  input  data_t     wrDataMemOut_i,
  input  memAddr_t  wrAddrMemOut_i,
  input  wire logic wrEnMemOut_i,
  input  memAddr_t  rdAddrMemOut_i,
  output data_t     rdDataMemIn0_o,
  output data_t     rdDataMemIn1_o,
  output data_t     rdDataMemOut_o,
  output data_t     rdDataConfigReg_o
);

  localparam int memDepth = 2 ** `AIP_MEM_ADDR_WIDTH;

  data_t memIn0 [0:memDepth-1];
  data_t memIn1 [0:memDepth-1];
  data_t memOut [0:memDepth-1];
  data_t confReg;

  // Host side fills the inputs
  always_ff @(posedge clk) begin
    if (wrEnMemIn0_i)
      memIn0[wrAddrMemIn0_i] <= dataInAIP_i;
  end

  always_ff @(posedge clk) begin
    if (wrEnMemIn1_i)
      memIn1[wrAddrMemIn1_i] <= dataInAIP_i;
  end

  always_ff @(posedge clk) begin
    if (wrEnMemOut_i)
      memOut[wrAddrMemOut_i] <= wrDataMemOut_i;  // Core results
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst)
      confReg <= '0;
    else if (wrEnConf_i)
      confReg <= dataInAIP_i;
  end

  // Asynchronous reads
  assign rdDataMemIn0_o    = memIn0[rdAddrMemIn0_i];
  assign rdDataMemIn1_o    = memIn1[rdAddrMemIn1_i];
  assign rdDataMemOut_o    = memOut[rdAddrMemOut_i];
  assign rdDataConfigReg_o = confReg;

  // Enables come from both decode and core
  knownWrEn: assert property (@(posedge clk) disable iff (!rst)
    !$isunknown({wrEnMemIn0_i, wrEnMemIn1_i, wrEnMemOut_i, wrEnConf_i}));

endmodule

`default_nettype wire

/* hdl/aipReadback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aip_params.svh"

module aipReadback import aipPkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  readSel_t   readSel_i,
  input  wire logic  wrEnStatus_i,
  input  data_t      dataInAIP_i,
  input  statusBits_t statusIPcore_i,
  input  statusBits_t intIPCore_i,
  input  data_t      rdDataMemOut_i,
  output data_t      dataOutAIP_o,
  output logic       intAIP_o
);

  statusWord_u hostWord;
  statusWord_u rdWord;
  statusBits_t flagReg;
  statusBits_t maskReg;
  statusBits_t clearBits;
  statusBits_t flagNext;
  logic        intReg;
  logic        clearsAll;

  assign hostWord = dataInAIP_i;

  assign clearBits = wrEnStatus_i ? hostWord.wr.clear : '0;
  assign flagNext  = (flagReg & ~clearBits) | intIPCore_i;  // New set beats clear

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      flagReg <= '0;
      maskReg <= '0;
      intReg  <= 1'b0;
    end else begin
      flagReg <= flagNext;
      if (wrEnStatus_i)
        maskReg <= hostWord.wr.newMask;
      intReg <= |(flagReg & maskReg);
    end
  end

  assign intAIP_o = intReg;

  always_comb begin
    rdWord           = '0;
    rdWord.rd.status = statusIPcore_i;
    rdWord.rd.flags  = flagReg;
    rdWord.rd.mask   = maskReg;
  end

  always_comb begin
    case (readSel_i)
      SEL_MEMOUT: dataOutAIP_o = rdDataMemOut_i;
      SEL_STATUS: dataOutAIP_o = rdWord;
      default:    dataOutAIP_o = `AIP_IP_ID;
    endcase
  end

  // Status write leaving no masked flag, no new interrupt
  assign clearsAll = wrEnStatus_i && (intIPCore_i == '0) &&
                     ((flagReg & ~hostWord.wr.clear & hostWord.wr.newMask) == '0);

  // Request drops two cycles after such a write
  intClear: assert property (@(posedge clk) disable iff (!rst)
    $past(clearsAll, 2) |-> !intAIP_o);

endmodule

`default_nettype wire

/* hdl/aipTop.sv */
`timescale 1ns/1ps
`default_nettype none

module aipTop import aipPkg::*; (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  en_i,
  // Host
  input  code_t      configAIP_i,
  input  data_t      dataInAIP_i,
  input  wire logic  writeAIP_i,
  input  wire logic  readAIP_i,
  input  wire logic  startAIP_i,
  output data_t      dataOutAIP_o,
  output logic       intAIP_o,
  // IP core
  input  memAddr_t   rdAddrMemIn0_i,
  input  memAddr_t   rdAddrMemIn1_i,
  input  data_t      wrDataMemOut_i,
  input  memAddr_t   wrAddrMemOut_i,
  input  wire logic  wrEnMemOut_i,
  input  statusBits_t statusIPcore_i,
  input  statusBits_t intIPCore_i,
  output data_t      rdDataMemIn0_o,
  output data_t      rdDataMemIn1_o,
  output data_t      rdDataConfigReg_o,
  output logic       startIPcore_o
);

  logic     wrEnMemIn0;
  logic     wrEnMemIn1;
  memAddr_t wrAddrMemIn0;
  memAddr_t wrAddrMemIn1;
  memAddr_t rdAddrMemOut;
  logic     wrEnConf;
  logic     wrEnStatus;
  readSel_t readSel;
  data_t    rdDataMemOut;

  assign startIPcore_o = startAIP_i;  // Straight to the core

  aipHostDecode decode_i (
    .clk            (clk),
    .rst            (rst),
    .en_i           (en_i),
    .configAIP_i    (configAIP_i),
    .writeAIP_i     (writeAIP_i),
    .readAIP_i      (readAIP_i),
    .dataInAIP_i    (dataInAIP_i),
    .wrEnMemIn0_o   (wrEnMemIn0),
    .wrEnMemIn1_o   (wrEnMemIn1),
    .wrAddrMemIn0_o (wrAddrMemIn0),
    .wrAddrMemIn1_o (wrAddrMemIn1),
    .rdAddrMemOut_o (rdAddrMemOut),
    .wrEnConf_o     (wrEnConf),
    .wrEnStatus_o   (wrEnStatus),
    .readSel_o      (readSel)
  );

  aipBuffers buffers_i (
    .clk               (clk),
    .rst               (rst),
    .dataInAIP_i       (dataInAIP_i),
    .wrEnMemIn0_i      (wrEnMemIn0),
    .wrEnMemIn1_i      (wrEnMemIn1),
    .wrAddrMemIn0_i    (wrAddrMemIn0),
    .wrAddrMemIn1_i    (wrAddrMemIn1),
    .rdAddrMemIn0_i    (rdAddrMemIn0_i),
    .rdAddrMemIn1_i    (rdAddrMemIn1_i),
    .wrEnConf_i        (wrEnConf),
    .wrDataMemOut_i    (wrDataMemOut_i),
    .wrAddrMemOut_i    (wrAddrMemOut_i),
    .wrEnMemOut_i      (wrEnMemOut_i),
    .rdAddrMemOut_i    (rdAddrMemOut),
    .rdDataMemIn0_o    (rdDataMemIn0_o),
    .rdDataMemIn1_o    (rdDataMemIn1_o),
    .rdDataMemOut_o    (rdDataMemOut),
    .rdDataConfigReg_o (rdDataConfigReg_o)
  );

  aipReadback readback_i (
    .clk            (clk),
    .rst            (rst),
    .readSel_i      (readSel),
    .wrEnStatus_i   (wrEnStatus),
    .dataInAIP_i    (dataInAIP_i),
    .statusIPcore_i (statusIPcore_i),
    .intIPCore_i    (intIPCore_i),
    .rdDataMemOut_i (rdDataMemOut),
    .dataOutAIP_o   (dataOutAIP_o),
    .intAIP_o       (intAIP_o)
  );

endmodule

`default_nettype wire

/* tb/aipTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "aip_params.svh"

module aipTb import aipPkg::*; ();

  typedef enum {HOST_WR, HOST_RD, CORE_RD, CORE_WR, CORE_SET, INT_CHK} rowKind_t;

  // sel is the code on host rows and the port on core reads (2 = config register)
  // CORE_SET rows carry status in data[7:0] and interrupts in data[15:8]
  typedef struct {
    rowKind_t kind;
    code_t    sel;
    data_t    data;
    logic     flag;  // en on writes, read strobe on reads, start on core sets
    memAddr_t addr;
    data_t    exp;
  } row_t;

  logic        clk;
  logic        rst;
  logic        en;
  code_t       configAIP;
  data_t       dataInAIP;
  logic        writeAIP;
  logic        readAIP;
  logic        startAIP;
  data_t       dataOutAIP;
  logic        intAIP;
  memAddr_t    rdAddrMemIn0;
  memAddr_t    rdAddrMemIn1;
  data_t       wrDataMemOut;
  memAddr_t    wrAddrMemOut;
  logic        wrEnMemOut;
  statusBits_t statusIPcore;
  statusBits_t intIPCore;
  data_t       rdDataMemIn0;
  data_t       rdDataMemIn1;
  data_t       rdDataConfigReg;
  logic        startIPcore;

  row_t  rows[$];
  data_t rngState = 32'd90;
  int    errors = 0;
  int    failedRows = 0;
  int    cycles = 0;
  int    cycleLimit = 1000;
  logic  rowOk;

  aipTop dut_i (
    .clk (clk), .rst (rst), .en_i (en),
    .configAIP_i (configAIP), .dataInAIP_i (dataInAIP), .writeAIP_i (writeAIP),
    .readAIP_i (readAIP), .startAIP_i (startAIP), .dataOutAIP_o (dataOutAIP),
    .intAIP_o (intAIP), .rdAddrMemIn0_i (rdAddrMemIn0), .rdAddrMemIn1_i (rdAddrMemIn1),
    .wrDataMemOut_i (wrDataMemOut), .wrAddrMemOut_i (wrAddrMemOut),
    .wrEnMemOut_i (wrEnMemOut), .statusIPcore_i (statusIPcore), .intIPCore_i (intIPCore),
    .rdDataMemIn0_o (rdDataMemIn0), .rdDataMemIn1_o (rdDataMemIn1),
    .rdDataConfigReg_o (rdDataConfigReg), .startIPcore_o (startIPcore)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic data_t xorshift(input data_t x);
    data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t nextWord();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic data_t statusWord(input statusBits_t mask, input statusBits_t flags,
                                       input statusBits_t status);
    statusRead_t s;
    s.zero   = '0;
    s.mask   = mask;
    s.flags  = flags;
    s.status = status;
    return s;
  endfunction

  task automatic addRow(input rowKind_t kind, input code_t sel, input data_t data,
                        input logic flag, input memAddr_t addr, input data_t exp);
    row_t r;
    r.kind = kind;
    r.sel  = sel;
    r.data = data;
    r.flag = flag;
    r.addr = addr;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    data_t w[4];
    data_t v[2];
    data_t x[3];
    data_t o[4];
    data_t c[2];
    foreach (w[i]) w[i] = nextWord();
    foreach (v[i]) v[i] = nextWord();
    foreach (x[i]) x[i] = nextWord();
    foreach (o[i]) o[i] = nextWord();
    foreach (c[i]) c[i] = nextWord();
    addRow(HOST_RD, `AIP_CODE_ID, '0, 1'b0, '0, `AIP_IP_ID);
    addRow(HOST_RD, 5'd9, '0, 1'b0, '0, `AIP_IP_ID);  // Unmapped
    addRow(CORE_RD, 5'd2, '0, 1'b0, '0, '0);          // Config out of reset
    // Memory 0 from address 3, memory 1 wraps at 31
    addRow(HOST_WR, `AIP_CODE_MEMIN0_ADDR, 32'd3, 1'b1, '0, '0);
    foreach (w[i]) addRow(HOST_WR, `AIP_CODE_MEMIN0_DATA, w[i], 1'b1, '0, '0);
    addRow(HOST_WR, `AIP_CODE_MEMIN1_ADDR, 32'd31, 1'b1, '0, '0);
    foreach (v[i]) addRow(HOST_WR, `AIP_CODE_MEMIN1_DATA, v[i], 1'b1, '0, '0);
    foreach (w[i]) addRow(CORE_RD, 5'd0, '0, 1'b0, memAddr_t'(3 + i), w[i]);
    addRow(CORE_RD, 5'd1, '0, 1'b0, 5'd31, v[0]);
    addRow(CORE_RD, 5'd1, '0, 1'b0, 5'd0, v[1]);
    // Pointer frozen at 7 while disabled
    addRow(HOST_WR, `AIP_CODE_MEMIN0_DATA, x[0], 1'b0, '0, '0);
    addRow(HOST_WR, `AIP_CODE_MEMIN0_DATA, x[1], 1'b0, '0, '0);
    addRow(CORE_RD, 5'd0, '0, 1'b0, 5'd7, x[1]);
    addRow(HOST_WR, `AIP_CODE_MEMIN0_DATA, x[2], 1'b1, '0, '0);
    addRow(CORE_RD, 5'd0, '0, 1'b0, 5'd7, x[2]);
    // Output memory
    foreach (o[i]) addRow(CORE_WR, '0, o[i], 1'b0, memAddr_t'(i), '0);
    addRow(HOST_RD, `AIP_CODE_MEMOUT_DATA, '0, 1'b1, '0, o[0]);  // Pointer moves off 0
    addRow(HOST_WR, `AIP_CODE_MEMOUT_ADDR, 32'd0, 1'b1, '0, '0);
    addRow(HOST_RD, `AIP_CODE_MEMOUT_DATA, '0, 1'b0, '0, o[0]);  // No pop
    foreach (o[i]) addRow(HOST_RD, `AIP_CODE_MEMOUT_DATA, '0, 1'b1, '0, o[i]);
    foreach (c[i]) addRow(HOST_WR, `AIP_CODE_CONF_DATA, c[i], 1'b1, '0, '0);
    addRow(CORE_RD, 5'd2, '0, 1'b0, '0, c[1]);
    addRow(CORE_SET, '0, 32'h0000_00A5, 1'b0, '0, '0);
    addRow(HOST_RD, `AIP_CODE_STATUS, '0, 1'b0, '0, statusWord(8'h00, 8'h00, 8'hA5));
    // Interrupt 0, then mask, then clear
    addRow(CORE_SET, '0, 32'h0000_01A5, 1'b0, '0, '0);
    addRow(HOST_RD, `AIP_CODE_STATUS, '0, 1'b0, '0, statusWord(8'h00, 8'h01, 8'hA5));
    addRow(INT_CHK, '0, '0, 1'b0, '0, 32'd0);
    addRow(HOST_WR, `AIP_CODE_STATUS, 32'h0001_0000, 1'b1, '0, '0);
    addRow(INT_CHK, '0, '0, 1'b0, '0, 32'd0);
    addRow(INT_CHK, '0, '0, 1'b0, '0, 32'd1);
    addRow(HOST_WR, `AIP_CODE_STATUS, 32'h0001_0100, 1'b1, '0, '0);
    addRow(INT_CHK, '0, '0, 1'b0, '0, 32'd1);
    addRow(INT_CHK, '0, '0, 1'b0, '0, 32'd0);
    addRow(HOST_RD, `AIP_CODE_STATUS, '0, 1'b0, '0, statusWord(8'h01, 8'h00, 8'hA5));
    addRow(CORE_SET, '0, 32'h0000_00A5, 1'b1, '0, '0);
    addRow(CORE_SET, '0, 32'h0000_00A5, 1'b0, '0, '0);
  endtask

  task automatic idleInputs();
    en           <= 1'b0;
    configAIP    <= '0;
    dataInAIP    <= '0;
    writeAIP     <= 1'b0;
    readAIP      <= 1'b0;
    startAIP     <= 1'b0;
    rdAddrMemIn0 <= '0;
    rdAddrMemIn1 <= '0;
    wrDataMemOut <= '0;
    wrAddrMemOut <= '0;
    wrEnMemOut   <= 1'b0;
    statusIPcore <= '0;
    intIPCore    <= '0;
  endtask

  task automatic driveRow(input row_t r);
    en           <= (r.kind == HOST_WR) ? r.flag : 1'b1;
    configAIP    <= (r.kind == HOST_WR || r.kind == HOST_RD) ? r.sel : `AIP_CODE_ID;
    dataInAIP    <= r.data;
    writeAIP     <= (r.kind == HOST_WR);
    readAIP      <= (r.kind == HOST_RD) && r.flag;
    startAIP     <= (r.kind == CORE_SET) && r.flag;
    rdAddrMemIn0 <= r.addr;
    rdAddrMemIn1 <= r.addr;
    wrDataMemOut <= r.data;
    wrAddrMemOut <= r.addr;
    wrEnMemOut   <= (r.kind == CORE_WR);
    if (r.kind == CORE_SET)
      statusIPcore <= r.data[7:0];  // Held until the next set
    intIPCore    <= (r.kind == CORE_SET) ? r.data[15:8] : '0;
  endtask

  task automatic checkData(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
      rowOk = 1'b0;
    end
  endtask

  task automatic checkStatus(input statusRead_t got, input statusRead_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: status word got mask %h flags %h status %h, expected %h %h %h",
               $time, got.mask, got.flags, got.status, exp.mask, exp.flags, exp.status);
      errors++;
      rowOk = 1'b0;
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
      errors++;
      rowOk = 1'b0;
    end
  endtask

  task automatic checkRow(input row_t r);
    case (r.kind)
      HOST_RD: begin
        if (r.sel == `AIP_CODE_STATUS)
          checkStatus(dataOutAIP, r.exp);
        else
          checkData("dataOutAIP_o", dataOutAIP, r.exp);
      end
      CORE_RD: begin
        if (r.sel == 5'd0)
          checkData("rdDataMemIn0_o", rdDataMemIn0, r.exp);
        else if (r.sel == 5'd1)
          checkData("rdDataMemIn1_o", rdDataMemIn1, r.exp);
        else
          checkData("rdDataConfigReg_o", rdDataConfigReg, r.exp);
      end
      CORE_SET: checkBit("startIPcore_o", startIPcore, r.flag);
      INT_CHK:  checkBit("intAIP_o", intAIP, r.exp[0]);
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the stimulus table did not finish within %0d cycles", cycleLimit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    idleInputs();
    rst <= 1'b0;
    buildTable();
    cycleLimit = rows.size() * 4 + 20;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk);
      driveRow(rows[i]);
      @(negedge clk);  // Outputs settled, next edge not yet taken
      rowOk = 1'b1;
      checkRow(rows[i]);
      if (!rowOk)
        failedRows++;
      $display("Row %0d %s %s", i, rows[i].kind.name(), rowOk ? "ok" : "failed");
    end
    @(posedge clk);
    idleInputs();
    $display("Rows %0d, failed %0d, mismatches %0d", rows.size(), failedRows, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/aipPkg.sv
hdl/aipHostDecode.sv
hdl/aipBuffers.sv
hdl/aipReadback.sv
hdl/aipTop.sv
tb/aipTb.sv

/* Makefile */
# Verilator build and run for the AIP host wrapper

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module aipTb -Mdir obj_dir -o VaipTb

run: compile
	@out="$$(./obj_dir/VaipTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
